//--- src/bp_pkg.sv
// --------------------------------------------------------------------------
// Branch prediction package
// Shared encodings, records and table sizes for the fetch prediction loop
// --------------------------------------------------------------------------

package bp_pkg;

	// ------------------------------------------------------------------------
	// Table and timing constants
	// ------------------------------------------------------------------------
	localparam int BTB_INDEX_W = 4;
	localparam int BTB_ENTRIES = 1 << BTB_INDEX_W;
	// Tag covers every word-address bit above the index
	localparam int BTB_TAG_W = 30 - BTB_INDEX_W;

	localparam int REFILL_CYCLES = 2;
	localparam int REFILL_CNT_W = $clog2(REFILL_CYCLES + 1);

	localparam logic [31:0] RESET_PC = 32'h1c00_0000;

	// ------------------------------------------------------------------------
	// Encodings
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		BR_INVALID,
		BR_CONDITION,
		BR_IMMEDIATE,
		BR_INDIRECT
	} branch_type_t;

	typedef enum logic [2:0] {
		CMP_EQL,
		CMP_NEQ,
		CMP_LSS,
		CMP_GER,
		CMP_LEQ,
		CMP_GEQ,
		CMP_LTU,
		CMP_GEU
	} cmp_type_t;

	typedef enum logic [1:0] {
		CLS_PC_RELATIVE,
		CLS_ABSOLUTE,
		CLS_CALL,
		CLS_RETURN
	} br_class_t;

	typedef enum logic {
		FS_RUN,
		FS_REFILL
	} fetch_state_t;

	// ------------------------------------------------------------------------
	// Records
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic         valid;
		branch_type_t branch_type;
		cmp_type_t    cmp_type;
		logic         branch_link;
		logic [25:0]  inst25_0;
	} decode_t;

	// npc is a word address
	typedef struct packed {
		logic        hit;
		logic        taken;
		logic [1:0]  ctr;
		logic [29:0] npc;
	} predict_t;

	// ctr is the counter value carried with the branch, not yet trained
	typedef struct packed {
		logic        flush;
		logic        btb_update;
		logic        br_taken;
		br_class_t   br_class;
		logic [29:0] pc;
		logic [29:0] br_target;
		logic [1:0]  ctr;
	} update_t;

endpackage : bp_pkg

//--- src/branch_feedback.sv
// --------------------------------------------------------------------------
// Branch feedback
// Resolves an executed branch, checks the prediction it carried and builds
// the BTB training record, the redirect and the link address
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module branch_feedback (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              csr_flush_i,
	input  logic              stall_i,
	input  logic [31:0]       pc_i,
	input  logic [31:0]       rj_i,
	input  logic [31:0]       rd_i,
	input  logic [31:0]       csr_target_i,
	input  bp_pkg::decode_t   decode_i,
	input  bp_pkg::predict_t  predict_i,
	output bp_pkg::update_t   update_o,
	output logic [31:0]       pc_link_o
);

	import bp_pkg::*;

	logic        taken;
	logic [31:0] next_pc;
	logic [31:0] offs_26;
	logic [31:0] offs_16;
	logic [4:0]  rj_index;
	logic [4:0]  rd_index;
	logic        br_valid;
	logic        mispredict;

	assign rj_index = decode_i.inst25_0[9:5];
	assign rd_index = decode_i.inst25_0[4:0];

	// LoongArch split immediate with the high part in the low field
	assign offs_26 = {{4{decode_i.inst25_0[9]}}, decode_i.inst25_0[9:0],
		decode_i.inst25_0[25:10], 2'b00};
	assign offs_16 = {{14{decode_i.inst25_0[25]}}, decode_i.inst25_0[25:10], 2'b00};

	always_comb begin
		taken = 1'b0;
		case (decode_i.branch_type)
			BR_CONDITION: begin
				case (decode_i.cmp_type)
					CMP_EQL: taken = rj_i == rd_i;
					CMP_NEQ: taken = rj_i != rd_i;
					CMP_LSS: taken = $signed(rj_i) < $signed(rd_i);
					CMP_GER: taken = $signed(rj_i) > $signed(rd_i);
					CMP_LEQ: taken = $signed(rj_i) <= $signed(rd_i);
					CMP_GEQ: taken = $signed(rj_i) >= $signed(rd_i);
					CMP_LTU: taken = rj_i < rd_i;
					CMP_GEU: taken = rj_i >= rd_i;
					default: taken = 1'b0;
				endcase
			end
			BR_IMMEDIATE, BR_INDIRECT: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// Resolved next PC is sequential when not taken
	always_comb begin
		case (decode_i.branch_type)
			BR_IMMEDIATE: next_pc = pc_i + offs_26;
			BR_INDIRECT:  next_pc = rj_i + offs_16;
			BR_CONDITION: next_pc = taken ? pc_i + offs_16 : pc_i + 32'd4;
			default:      next_pc = pc_i + 32'd4;
		endcase
	end

	assign pc_link_o = pc_i + 32'd4;

	// ------------------------------------------------------------------------
	// Update record
	// ------------------------------------------------------------------------
	assign br_valid   = decode_i.valid & ~stall_i;
	assign mispredict = {predict_i.npc, 2'b00} != next_pc;

	assign update_o.flush      = (br_valid & mispredict) | csr_flush_i;
	assign update_o.btb_update = br_valid;
	assign update_o.br_taken   = taken;
	assign update_o.pc         = pc_i[31:2];
	assign update_o.br_target  = csr_flush_i ? csr_target_i[31:2] : next_pc[31:2];
	assign update_o.ctr        = predict_i.ctr;

	// A linking indirect jump is a call before anything else
	always_comb begin
		if (decode_i.branch_link ||
				(decode_i.branch_type == BR_INDIRECT && rd_index == 5'd1)) begin
			update_o.br_class = CLS_CALL;
		end else if (decode_i.branch_type == BR_INDIRECT && rj_index == 5'd1 &&
				offs_16 == 32'd0) begin
			update_o.br_class = CLS_RETURN;
		end else if (decode_i.branch_type == BR_IMMEDIATE ||
				decode_i.branch_type == BR_INDIRECT) begin
			update_o.br_class = CLS_ABSOLUTE;
		end else begin
			update_o.br_class = CLS_PC_RELATIVE;
		end
	end

	// PC-relative targets stay aligned as long as the pipeline hands in aligned PCs
	a_rel_target_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		(decode_i.valid && decode_i.branch_type != BR_INDIRECT) |-> next_pc[1:0] == 2'b00);

endmodule : branch_feedback

//--- src/branch_target_buffer.sv
// --------------------------------------------------------------------------
// Branch target buffer
// Direct-mapped table of tags, targets and 2-bit counters, looked up by the
// fetch PC and trained by resolved branches
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module branch_target_buffer (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic [31:0]       fetch_pc_i,
	output bp_pkg::predict_t  predict_o,
	input  bp_pkg::update_t   update_i
);

	import bp_pkg::*;

	logic [BTB_ENTRIES-1:0] valid_q;
	logic [BTB_TAG_W-1:0]   tag_q    [BTB_ENTRIES];
	logic [29:0]            target_q [BTB_ENTRIES];
	logic [1:0]             ctr_q    [BTB_ENTRIES];

	logic [BTB_INDEX_W-1:0] rd_idx;
	logic [BTB_TAG_W-1:0]   rd_tag;
	logic                   hit;
	logic                   pred_taken;

	logic [BTB_INDEX_W-1:0] wr_idx;
	logic [BTB_TAG_W-1:0]   wr_tag;
	logic [1:0]             ctr_next;

	// ------------------------------------------------------------------------
	// Lookup
	// ------------------------------------------------------------------------
	assign rd_idx = fetch_pc_i[BTB_INDEX_W+1:2];
	assign rd_tag = fetch_pc_i[31:BTB_INDEX_W+2];

	assign hit        = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
	assign pred_taken = hit && ctr_q[rd_idx][1];

	assign predict_o.hit   = hit;
	assign predict_o.taken = pred_taken;
	assign predict_o.ctr   = ctr_q[rd_idx];
	assign predict_o.npc   = pred_taken ? target_q[rd_idx] : fetch_pc_i[31:2] + 30'd1;

	// ------------------------------------------------------------------------
	// Training
	// ------------------------------------------------------------------------
	assign wr_idx = update_i.pc[BTB_INDEX_W-1:0];
	assign wr_tag = update_i.pc[29:BTB_INDEX_W];

	// Saturate the counter that travelled with the branch
	always_comb begin
		if (update_i.br_taken) begin
			ctr_next = (update_i.ctr == 2'b11) ? 2'b11 : update_i.ctr + 2'd1;
		end else begin
			ctr_next = (update_i.ctr == 2'b00) ? 2'b00 : update_i.ctr - 2'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
			for (int i = 0; i < BTB_ENTRIES; i++) begin
				ctr_q[i] <= 2'b01;
			end
		end else if (update_i.btb_update) begin
			ctr_q[wr_idx] <= ctr_next;
			if (update_i.br_taken) begin
				valid_q[wr_idx] <= 1'b1;
			end
		end
	end

	// Only taken branches allocate
	always_ff @(posedge clk) begin
		if (update_i.btb_update && update_i.br_taken) begin
			tag_q[wr_idx]    <= wr_tag;
			target_q[wr_idx] <= update_i.br_target;
		end
	end

	// Counter moves towards the outcome and never wraps
	a_ctr_no_wrap: assert property (@(posedge clk) disable iff (!rst_n_i)
		update_i.btb_update |=> ($past(update_i.br_taken) ?
			ctr_q[$past(wr_idx)] >= $past(update_i.ctr) :
			ctr_q[$past(wr_idx)] <= $past(update_i.ctr)));

	// A taken write makes that PC hit on its next lookup
	a_hit_after_alloc: assert property (@(posedge clk) disable iff (!rst_n_i)
		(update_i.btb_update && update_i.br_taken) |=>
			(fetch_pc_i[31:2] != $past(update_i.pc)) || hit);

endmodule : branch_target_buffer

//--- src/fetch_ctrl.sv
// --------------------------------------------------------------------------
// Fetch control
// Owns the fetch PC, follows predictions and handles redirect refill
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module fetch_ctrl (
	input  logic              clk,
	input  logic              rst_n_i,
	input  bp_pkg::update_t   update_i,
	input  bp_pkg::predict_t  predict_i,
	input  logic              timer_done_i,
	output logic              timer_start_o,
	output logic [31:0]       fetch_pc_o,
	output logic              fetch_valid_o
);

	import bp_pkg::*;

	fetch_state_t state_q;
	fetch_state_t state_d;
	logic [31:0]  pc_q;
	logic [31:0]  pc_d;

	// A flush wins over the prediction and restarts a running refill
	always_comb begin
		state_d = state_q;
		pc_d    = pc_q;
		if (update_i.flush) begin
			state_d = FS_REFILL;
			pc_d    = {update_i.br_target, 2'b00};
		end else if (state_q == FS_RUN) begin
			pc_d = {predict_i.npc, 2'b00};
		end else if (timer_done_i) begin
			state_d = FS_RUN;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= FS_REFILL;
			pc_q    <= RESET_PC;
		end else begin
			state_q <= state_d;
			pc_q    <= pc_d;
		end
	end

	assign timer_start_o = update_i.flush;
	assign fetch_pc_o    = pc_q;
	assign fetch_valid_o = (state_q == FS_RUN);

	// Fetch stays off in refill until the timer has run out
	a_no_valid_in_refill: assert property (@(posedge clk) disable iff (!rst_n_i)
		(state_q == FS_REFILL && !timer_done_i) |=> !fetch_valid_o);

endmodule : fetch_ctrl

//--- src/refill_timer.sv
// --------------------------------------------------------------------------
// Refill timer
// Counts the bubble cycles that follow a fetch redirect
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module refill_timer (
	input  logic clk,
	input  logic rst_n_i,
	input  logic start_i,
	output logic done_o
);

	import bp_pkg::*;

	// The start cycle is itself the first bubble, hence one less
	localparam logic [REFILL_CNT_W-1:0] LOAD_VAL = REFILL_CNT_W'(REFILL_CYCLES - 1);

	logic [REFILL_CNT_W-1:0] cnt_q;

	// Comes out of reset loaded for the start-up bubble
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q <= LOAD_VAL;
		end else if (start_i) begin
			cnt_q <= LOAD_VAL;
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	assign done_o = (cnt_q == '0);

endmodule : refill_timer

//--- src/bp_top.sv
// --------------------------------------------------------------------------
// Branch prediction front end
// Fetch control, refill timer, BTB and branch feedback in one loop
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module bp_top (
	input  logic              clk,
	input  logic              rst_n_i,
	input  bp_pkg::decode_t   ex_decode_i,
	input  bp_pkg::predict_t  ex_predict_i,
	input  logic [31:0]       ex_pc_i,
	input  logic [31:0]       rj_i,
	input  logic [31:0]       rd_i,
	input  logic              stall_i,
	input  logic              csr_flush_i,
	input  logic [31:0]       csr_target_i,
	output logic [31:0]       fetch_pc_o,
	output logic              fetch_valid_o,
	output bp_pkg::predict_t  fetch_predict_o,
	output logic [31:0]       pc_link_o,
	output bp_pkg::update_t   update_o
);

	logic timer_start;
	logic timer_done;

	// ------------------------------------------------------------------------
	// Fetch side
	// ------------------------------------------------------------------------
	fetch_ctrl u_fetch_ctrl (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.update_i      (update_o),
		.predict_i     (fetch_predict_o),
		.timer_done_i  (timer_done),
		.timer_start_o (timer_start),
		.fetch_pc_o    (fetch_pc_o),
		.fetch_valid_o (fetch_valid_o)
	);

	refill_timer u_refill_timer (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.start_i (timer_start),
		.done_o  (timer_done)
	);

	branch_target_buffer u_btb (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.fetch_pc_i (fetch_pc_o),
		.predict_o  (fetch_predict_o),
		.update_i   (update_o)
	);

	// ------------------------------------------------------------------------
	// Execute side
	// ------------------------------------------------------------------------
	branch_feedback u_branch_feedback (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.csr_flush_i  (csr_flush_i),
		.stall_i      (stall_i),
		.pc_i         (ex_pc_i),
		.rj_i         (rj_i),
		.rd_i         (rd_i),
		.csr_target_i (csr_target_i),
		.decode_i     (ex_decode_i),
		.predict_i    (ex_predict_i),
		.update_o     (update_o),
		.pc_link_o    (pc_link_o)
	);

endmodule : bp_top

//--- verification/tb_bp_top.sv
// --------------------------------------------------------------------------
// Branch prediction front end testbench
// Drives resolved branches into the DUT, mirrors the BTB and fetch PC in a
// reference model and compares every output once per cycle
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_bp_top;

	import bp_pkg::*;

	logic        clk;
	logic        rst_n_i;
	decode_t     ex_decode_i;
	predict_t    ex_predict_i;
	logic [31:0] ex_pc_i;
	logic [31:0] rj_i;
	logic [31:0] rd_i;
	logic        stall_i;
	logic        csr_flush_i;
	logic [31:0] csr_target_i;
	logic [31:0] fetch_pc_o;
	logic        fetch_valid_o;
	predict_t    fetch_predict_o;
	logic [31:0] pc_link_o;
	update_t     update_o;

	// Reference BTB and fetch state
	logic                 m_valid  [BTB_ENTRIES];
	logic [BTB_TAG_W-1:0] m_tag    [BTB_ENTRIES];
	logic [29:0]          m_target [BTB_ENTRIES];
	logic [1:0]           m_ctr    [BTB_ENTRIES];
	logic [31:0]          m_pc;
	int                   m_bubbles;
	logic [31:0]          lfsr_q;

	bp_top uut (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.ex_decode_i     (ex_decode_i),
		.ex_predict_i    (ex_predict_i),
		.ex_pc_i         (ex_pc_i),
		.rj_i            (rj_i),
		.rd_i            (rd_i),
		.stall_i         (stall_i),
		.csr_flush_i     (csr_flush_i),
		.csr_target_i    (csr_target_i),
		.fetch_pc_o      (fetch_pc_o),
		.fetch_valid_o   (fetch_valid_o),
		.fetch_predict_o (fetch_predict_o),
		.pc_link_o       (pc_link_o),
		.update_o        (update_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Random source and helpers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic decode_t mk_dec(input branch_type_t t, input cmp_type_t c,
			input logic link, input logic [25:0] inst);
		decode_t d;
		d.valid       = 1'b1;
		d.branch_type = t;
		d.cmp_type    = c;
		d.branch_link = link;
		d.inst25_0    = inst;
		return d;
	endfunction

	// Word offset in LoongArch order, low half on top
	function automatic logic [25:0] imm26(input logic [25:0] woff);
		return {woff[15:0], woff[25:16]};
	endfunction

	task automatic check_eq(input string name, input logic [66:0] act, input logic [66:0] exp);
		if (act !== exp) begin
			$display("Error: %s is 0x%0h, expected 0x%0h", name, act, exp);
			$display("** FAIL **");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ------------------------------------------------------------------------
	// Reference models
	// ------------------------------------------------------------------------
	function automatic update_t ref_feedback(
		input  decode_t     d,
		input  predict_t    p,
		input  logic [31:0] pc,
		input  logic [31:0] rj,
		input  logic [31:0] rd,
		input  logic [31:0] tgt_csr,
		input  logic        stall,
		input  logic        csr,
		output logic [31:0] link
	);
		update_t     u;
		logic [31:0] off16;
		logic [31:0] off26;
		logic [31:0] tgt;
		logic [31:0] nxt;
		logic        tk;
		logic        ind;
		off16 = {{16{d.inst25_0[25]}}, d.inst25_0[25:10]} << 2;
		off26 = {{6{d.inst25_0[9]}}, d.inst25_0[9:0], d.inst25_0[25:10]} << 2;
		tk    = 1'b1;
		tgt   = pc + 32'd4;
		case (d.branch_type)
			BR_IMMEDIATE: tgt = pc + off26;
			BR_INDIRECT:  tgt = rj + off16;
			BR_CONDITION: begin
				tgt = pc + off16;
				case (d.cmp_type)
					CMP_EQL: tk = (rj == rd);
					CMP_NEQ: tk = (rj != rd);
					CMP_LSS: tk = ($signed(rj) < $signed(rd));
					CMP_GER: tk = ($signed(rj) > $signed(rd));
					CMP_LEQ: tk = ($signed(rj) <= $signed(rd));
					CMP_GEQ: tk = ($signed(rj) >= $signed(rd));
					CMP_LTU: tk = (rj < rd);
					default: tk = (rj >= rd);
				endcase
			end
			default: tk = 1'b0;
		endcase
		nxt          = tk ? tgt : pc + 32'd4;
		ind          = (d.branch_type == BR_INDIRECT);
		u.flush      = csr | (d.valid & ~stall & ({p.npc, 2'b00} != nxt));
		u.btb_update = d.valid & ~stall;
		u.br_taken   = tk;
		u.pc         = pc[31:2];
		u.br_target  = csr ? tgt_csr[31:2] : nxt[31:2];
		u.ctr        = p.ctr;
		if (d.branch_link || (ind && d.inst25_0[4:0] == 5'd1))
			u.br_class = CLS_CALL;
		else if (ind && d.inst25_0[9:5] == 5'd1 && d.inst25_0[25:10] == 16'h0)
			u.br_class = CLS_RETURN;
		else if (ind || d.branch_type == BR_IMMEDIATE)
			u.br_class = CLS_ABSOLUTE;
		else
			u.br_class = CLS_PC_RELATIVE;
		link = pc + 32'd4;
		return u;
	endfunction

	function automatic predict_t ref_predict(input logic [31:0] pc);
		predict_t p;
		int       idx;
		idx     = int'(pc[BTB_INDEX_W+1:2]);
		p.hit   = m_valid[idx] && (m_tag[idx] == pc[31:BTB_INDEX_W+2]);
		p.taken = p.hit && m_ctr[idx][1];
		p.ctr   = m_ctr[idx];
		p.npc   = p.taken ? m_target[idx] : pc[31:2] + 30'd1;
		return p;
	endfunction

	// Outputs are compared mid-cycle, then the model takes the coming edge
	initial begin : compare_proc
		update_t     exp_upd;
		predict_t    exp_pred;
		logic [31:0] exp_link;
		int          idx;
		m_pc      = RESET_PC;
		m_bubbles = REFILL_CYCLES;
		for (int i = 0; i < BTB_ENTRIES; i++) begin
			m_valid[i]  = 1'b0;
			m_tag[i]    = '0;
			m_target[i] = '0;
			m_ctr[i]    = 2'b01;
		end
		forever begin
			@(negedge clk);
			if (rst_n_i) begin
				exp_upd  = ref_feedback(ex_decode_i, ex_predict_i, ex_pc_i, rj_i, rd_i,
					csr_target_i, stall_i, csr_flush_i, exp_link);
				exp_pred = ref_predict(m_pc);
				check_eq("update_o.flush", update_o.flush, exp_upd.flush);
				check_eq("update_o.btb_update", update_o.btb_update, exp_upd.btb_update);
				check_eq("update_o.br_taken", update_o.br_taken, exp_upd.br_taken);
				check_eq("update_o.br_class", update_o.br_class, exp_upd.br_class);
				check_eq("update_o.pc", update_o.pc, exp_upd.pc);
				check_eq("update_o.br_target", update_o.br_target, exp_upd.br_target);
				check_eq("update_o.ctr", update_o.ctr, exp_upd.ctr);
				check_eq("pc_link_o", pc_link_o, exp_link);
				check_eq("fetch_valid_o", fetch_valid_o, m_bubbles == 0);
				check_eq("fetch_pc_o", fetch_pc_o, m_pc);
				check_eq("fetch_predict_o", fetch_predict_o, exp_pred);
				if (exp_upd.btb_update) begin
					idx = int'(exp_upd.pc[BTB_INDEX_W-1:0]);
					if (exp_upd.br_taken) begin
						m_ctr[idx]    = exp_upd.ctr + {1'b0, exp_upd.ctr != 2'b11};
						m_valid[idx]  = 1'b1;
						m_tag[idx]    = exp_upd.pc[29:BTB_INDEX_W];
						m_target[idx] = exp_upd.br_target;
					end else begin
						m_ctr[idx] = exp_upd.ctr - {1'b0, exp_upd.ctr != 2'b00};
					end
				end
				if (exp_upd.flush) begin
					m_pc      = {exp_upd.br_target, 2'b00};
					m_bubbles = REFILL_CYCLES;
				end else if (m_bubbles > 0) begin
					m_bubbles--;
				end else begin
					m_pc = {exp_pred.npc, 2'b00};
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus tasks
	// ------------------------------------------------------------------------
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic idle();
		ex_decode_i  = '0;
		ex_predict_i = '0;
		stall_i      = 1'b0;
		csr_flush_i  = 1'b0;
		csr_target_i = '0;
	endtask

	// Carries either the correct next PC or a wrong one
	task automatic apply_branch(input decode_t d, input logic [31:0] pc, input logic [31:0] rj,
			input logic [31:0] rd, input logic good);
		update_t     u;
		predict_t    p;
		logic [31:0] link;
		p     = '0;
		p.ctr = 2'b01;
		u     = ref_feedback(d, p, pc, rj, rd, 32'h0, 1'b0, 1'b0, link);
		p.npc = good ? u.br_target : u.br_target + 30'd1;
		ex_decode_i  = d;
		ex_predict_i = p;
		ex_pc_i      = pc;
		rj_i         = rj;
		rd_i         = rd;
	endtask

	task automatic wait_refill(input logic [31:0] tgt);
		int n;
		n = 0;
		while (!fetch_valid_o) begin
			n++;
			if (n > 4 * REFILL_CYCLES + 4) begin
				$display("Timeout: fetch never became valid after a redirect");
				$display("** FAIL **");
				$fatal(1, "refill timeout");
			end
			step();
		end
		check_eq("refill bubble count", n, REFILL_CYCLES);
		check_eq("fetch_pc_o after refill", fetch_pc_o, tgt);
	endtask

	task automatic redirect(input logic [31:0] tgt);
		idle();
		csr_flush_i  = 1'b1;
		csr_target_i = tgt;
		step();
		idle();
		wait_refill(tgt);
	endtask

	task automatic check_class(input decode_t d, input br_class_t cls);
		apply_branch(d, 32'h1c00_0040, 32'h1c00_2000, 32'd5, 1'b1);
		@(negedge clk);
		check_eq("update_o.br_class", update_o.br_class, cls);
		step();
		idle();
	endtask

	// Branch in execute that trains the BTB with the counter fetch would see
	task automatic train(input decode_t d, input logic [31:0] pc, input logic [31:0] rj,
			input logic [31:0] rd);
		apply_branch(d, pc, rj, rd, 1'b1);
		ex_predict_i = ref_predict(pc);
		step();
		idle();
	endtask

	task automatic random_cycle();
		decode_t     d;
		logic [1:0]  t;
		logic [3:0]  r;
		logic [31:0] rj;
		logic [31:0] rd;
		logic [31:0] pc;
		idle();
		r = 4'(rand_bits(4));
		if (r >= 4'd6) begin
			t  = 2'(rand_bits(2));
			d  = mk_dec((t == 2'd0) ? BR_CONDITION : branch_type_t'(t),
				cmp_type_t'(3'(rand_bits(3))), (t == 2'd2) & rand_bits(1) != 0,
				26'(rand_bits(26)));
			rj = rand_bits(32);
			rd = (rand_bits(2) == 0) ? rj : rand_bits(32);
			pc = RESET_PC | {22'h0, 8'(rand_bits(8)), 2'b00};
			apply_branch(d, pc, rj, rd, rand_bits(1) != 0);
			ex_predict_i.ctr = 2'(rand_bits(2));
			stall_i          = (r == 4'd6);
			csr_flush_i      = (r == 4'd7);
			csr_target_i     = RESET_PC | {22'h0, 8'(rand_bits(8)), 2'b00};
		end
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin : stimulus
		decode_t     d;
		logic [31:0] rj;
		logic [31:0] rd;
		lfsr_q  = 32'h9120_7344;
		rst_n_i = 1'b0;
		ex_pc_i = RESET_PC;
		rj_i    = '0;
		rd_i    = '0;
		idle();
		repeat (8) @(posedge clk);
		#1 rst_n_i = 1'b1;
		wait_refill(RESET_PC);

		// All eight compares, equal and sign-split operands included
		for (int c = 0; c < 8; c++) begin
			for (int k = 0; k < 4; k++) begin
				rj = rand_bits(32);
				rd = (k == 0) ? rj : ((k == 1) ? rj ^ 32'h8000_0000 : rand_bits(32));
				d  = mk_dec(BR_CONDITION, cmp_type_t'(3'(c)), 1'b0, 26'(rand_bits(26)));
				apply_branch(d, RESET_PC + 32'h40, rj, rd, 1'b1);
				step();
				idle();
			end
		end

		check_class(mk_dec(BR_IMMEDIATE, CMP_EQL, 1'b1, imm26(26'h10)), CLS_CALL);
		check_class(mk_dec(BR_INDIRECT, CMP_EQL, 1'b0, {16'h0004, 5'd7, 5'd1}), CLS_CALL);
		check_class(mk_dec(BR_INDIRECT, CMP_EQL, 1'b0, {16'h0000, 5'd1, 5'd0}), CLS_RETURN);
		check_class(mk_dec(BR_INDIRECT, CMP_EQL, 1'b0, {16'h0004, 5'd1, 5'd0}), CLS_ABSOLUTE);
		check_class(mk_dec(BR_IMMEDIATE, CMP_EQL, 1'b0, imm26(26'h10)), CLS_ABSOLUTE);
		check_class(mk_dec(BR_CONDITION, CMP_NEQ, 1'b0, {16'h0008, 5'd1, 5'd0}), CLS_PC_RELATIVE);

		// Flush decision on a plain jump to 1c00_1100
		d = mk_dec(BR_IMMEDIATE, CMP_EQL, 1'b0, imm26(26'h40));
		apply_branch(d, 32'h1c00_1000, 32'h0, 32'h0, 1'b1);
		@(negedge clk);
		check_eq("update_o.flush", update_o.flush, 1'b0);
		check_eq("update_o.btb_update", update_o.btb_update, 1'b1);
		step();
		apply_branch(d, 32'h1c00_1000, 32'h0, 32'h0, 1'b0);
		@(negedge clk);
		check_eq("update_o.flush", update_o.flush, 1'b1);
		check_eq("update_o.br_target", update_o.br_target, 30'h0700_0440);
		step();
		idle();
		wait_refill(32'h1c00_1100);
		apply_branch(d, 32'h1c00_1000, 32'h0, 32'h0, 1'b0);
		stall_i = 1'b1;
		@(negedge clk);
		check_eq("update_o.flush", update_o.flush, 1'b0);
		check_eq("update_o.btb_update", update_o.btb_update, 1'b0);
		step();
		apply_branch(d, 32'h1c00_1000, 32'h0, 32'h0, 1'b1);
		csr_flush_i  = 1'b1;
		csr_target_i = 32'h1c00_3000;
		@(negedge clk);
		check_eq("update_o.flush", update_o.flush, 1'b1);
		check_eq("update_o.br_target", update_o.br_target, 30'h0700_0c00);
		step();
		idle();
		wait_refill(32'h1c00_3000);

		// Train 1c00_0200 as taken towards 1c00_0280, then untrain it
		d = mk_dec(BR_CONDITION, CMP_EQL, 1'b0, {16'h0020, 5'd4, 5'd5});
		train(d, 32'h1c00_0200, 32'd9, 32'd9);
		train(d, 32'h1c00_0200, 32'd9, 32'd9);
		redirect(32'h1c00_0200);
		check_eq("fetch_predict_o.taken", fetch_predict_o.taken, 1'b1);
		check_eq("fetch_predict_o.npc", fetch_predict_o.npc, 30'h0700_00a0);
		step();
		check_eq("fetch_pc_o", fetch_pc_o, 32'h1c00_0280);
		train(d, 32'h1c00_0200, 32'd1, 32'd2);
		train(d, 32'h1c00_0200, 32'd1, 32'd2);
		redirect(32'h1c00_0200);
		check_eq("fetch_predict_o.taken", fetch_predict_o.taken, 1'b0);
		check_eq("fetch_predict_o.npc", fetch_predict_o.npc, 30'h0700_0081);

		for (int i = 0; i < 400; i++) begin
			random_cycle();
			step();
		end
		idle();
		step();

		$display("** PASS **");
		$finish;
	end

endmodule : tb_bp_top

//--- filelist.f
src/bp_pkg.sv
src/branch_feedback.sv
src/branch_target_buffer.sv
src/fetch_ctrl.sv
src/refill_timer.sv
src/bp_top.sv
verification/tb_bp_top.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_bp_top -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_bp_top); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
